// ==== hw/csr_pkg.sv ====
//****************************
// register indices, constants and
// packed types of the csr block
//****************************
package csr_pkg;

  localparam int REG_IDX_W = 5;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [31:0]          csr_word_t;
  // wide enough for up to four PEs
  typedef logic [1:0]           pe_num_t;

  localparam logic [15:0] GUARD_KEY        = 16'h1234;
  localparam csr_word_t   NS_PER_SEC       = 32'd1_000_000_000;
  localparam csr_word_t   HW_VERSION       = 32'h0001_0002;
  localparam csr_word_t   SW_VERSION_RESET = 32'h2022_0000;
  localparam logic [7:0]  NS_PER_CLK_RESET = 8'd20;

  // register map, word index from address bits 6..2
  localparam reg_idx_t IDX_GUARD       = 5'd1;
  localparam reg_idx_t IDX_SW_VER      = 5'd2;
  localparam reg_idx_t IDX_HW_VER      = 5'd3;
  localparam reg_idx_t IDX_PE_ID       = 5'd4;
  localparam reg_idx_t IDX_SUB_S       = 5'd9;
  localparam reg_idx_t IDX_ADD_S       = 5'd10;
  localparam reg_idx_t IDX_SUB_NS      = 5'd11;
  // write adds nanoseconds, read returns them
  localparam reg_idx_t IDX_ADD_NS      = 5'd12;
  localparam reg_idx_t IDX_READ_S      = 5'd13;
  localparam reg_idx_t IDX_CMP         = 5'd14;
  localparam reg_idx_t IDX_SHARED_BASE = 5'd16;
  localparam reg_idx_t IDX_STEP        = 5'd31;

  // the one write applied this cycle
  typedef struct packed {
    logic      valid;
    pe_num_t   pe;
    reg_idx_t  idx;
    csr_word_t data;
  } wr_cmd_t;

  // sign set means add, is_sec set means seconds
  typedef struct packed {
    logic      valid;
    logic      sign;
    logic      is_sec;
    csr_word_t amount;
  } time_adj_t;

  typedef struct packed {
    csr_word_t sec;
    csr_word_t ns;
  } sys_time_t;

endpackage

// ==== hw/csr_req_capture.sv ====
//****************************
// per-PE write holding registers
// and the rotating turn ring
//****************************
`timescale 1ns/100ps

module csr_req_capture import csr_pkg::*; #(
  parameter int NUM_PE = 3
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic [NUM_PE*32-1:0] i_addr,
  input  logic [NUM_PE-1:0]    i_wren,
  input  logic [NUM_PE*32-1:0] i_din,
  output wr_cmd_t              o_wr_cmd
);

  logic      [NUM_PE-1:0] r_turn;
  logic      [NUM_PE-1:0] r_pending;
  reg_idx_t  [NUM_PE-1:0] r_idx;
  csr_word_t [NUM_PE-1:0] r_data;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_turn    <= NUM_PE'(1);
      r_pending <= '0;
    end else begin
      // one-hot rotate, a single PE keeps the turn forever
      r_turn <= (r_turn << 1) | (r_turn >> (NUM_PE - 1));
      for (int p = 0; p < NUM_PE; p++) begin
        if (i_wren[p]) begin
          r_pending[p] <= 1'b1;
        end else if (r_turn[p]) begin
          r_pending[p] <= 1'b0;
        end
      end
    end
  end

  // newer request overwrites an older one still waiting
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < NUM_PE; p++) begin
      if (i_wren[p]) begin
        r_idx[p]  <= i_addr[p*32+2 +: REG_IDX_W];
        r_data[p] <= i_din[p*32 +: 32];
      end
    end
  end

  // present the turn holder's pending write
  always_comb begin
    o_wr_cmd = '0;
    for (int p = 0; p < NUM_PE; p++) begin
      if (r_turn[p]) begin
        o_wr_cmd.valid = r_pending[p];
        o_wr_cmd.pe    = pe_num_t'(p);
        o_wr_cmd.idx   = r_idx[p];
        o_wr_cmd.data  = r_data[p];
      end
    end
  end

endmodule

// ==== hw/csr_regfile.sv ====
//****************************
// guard, version, shared, compare and step
// registers, write decode, registered reads
//****************************
`timescale 1ns/100ps

module csr_regfile import csr_pkg::*; #(
  parameter int NUM_PE     = 3,
  parameter int NUM_SHARED = 8
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  wr_cmd_t                i_wr_cmd,
  input  logic [NUM_PE*32-1:0]   i_addr,
  input  logic [NUM_PE-1:0]      i_rden,
  input  sys_time_t              i_time,
  output logic [NUM_PE*32-1:0]   o_dout,
  output logic [NUM_PE-1:0]      o_dout_valid,
  output time_adj_t              o_time_adj,
  output logic [7:0]             o_step,
  output csr_word_t [NUM_PE-1:0] o_cmp
);

  logic      [NUM_PE-1:0][15:0] r_guard;
  csr_word_t                    r_sw_version;
  csr_word_t [NUM_SHARED-1:0]   r_shared;
  // seconds latched by a nanoseconds read
  csr_word_t [NUM_PE-1:0]       r_sec_snap;
  logic                         w_guard_ok;
  reg_idx_t                     w_rd_idx  [NUM_PE];
  csr_word_t                    w_rd_data [NUM_PE];

  // guard state of the PE whose write is applied now
  always_comb begin
    w_guard_ok = 1'b0;
    for (int p = 0; p < NUM_PE; p++) begin
      if (i_wr_cmd.pe == pe_num_t'(p)) begin
        w_guard_ok = (r_guard[p] == GUARD_KEY);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_guard      <= '0;
      r_sw_version <= SW_VERSION_RESET;
      r_shared     <= '0;
      o_cmp        <= '0;
      o_step       <= NS_PER_CLK_RESET;
      o_time_adj   <= '0;
      o_dout_valid <= '0;
    end else begin
      o_time_adj.valid <= 1'b0;
      for (int p = 0; p < NUM_PE; p++) begin
        // read strobe or write finish
        o_dout_valid[p] <= i_rden[p] | (i_wr_cmd.valid && i_wr_cmd.pe == pe_num_t'(p));
        if (i_wr_cmd.valid && i_wr_cmd.pe == pe_num_t'(p)) begin
          // any write disarms the guard unless it loads a new key
          r_guard[p] <= (i_wr_cmd.idx == IDX_GUARD) ? i_wr_cmd.data[15:0] : 16'h0;
          if (i_wr_cmd.idx == IDX_CMP) begin
            o_cmp[p] <= i_wr_cmd.data;
          end
        end
      end
      if (i_wr_cmd.valid) begin
        case (i_wr_cmd.idx)
          IDX_SW_VER: if (w_guard_ok) r_sw_version <= i_wr_cmd.data;
          IDX_STEP:   if (w_guard_ok) o_step <= i_wr_cmd.data[7:0];
          IDX_SUB_S, IDX_ADD_S, IDX_SUB_NS, IDX_ADD_NS: begin
            if (w_guard_ok) begin
              o_time_adj <= '{valid:  1'b1,
                              sign:   (i_wr_cmd.idx == IDX_ADD_S ||
                                       i_wr_cmd.idx == IDX_ADD_NS),
                              is_sec: (i_wr_cmd.idx == IDX_SUB_S ||
                                       i_wr_cmd.idx == IDX_ADD_S),
                              amount: i_wr_cmd.data};
            end
          end
          default: begin
            for (int k = 0; k < NUM_SHARED; k++) begin
              if (i_wr_cmd.idx == reg_idx_t'(IDX_SHARED_BASE + k)) begin
                r_shared[k] <= i_wr_cmd.data;
              end
            end
          end
        endcase
      end
    end
  end

  // read mux per PE, unused indices give zero
  always_comb begin
    for (int p = 0; p < NUM_PE; p++) begin
      w_rd_idx[p]  = i_addr[p*32+2 +: REG_IDX_W];
      w_rd_data[p] = '0;
      case (w_rd_idx[p])
        IDX_GUARD:  w_rd_data[p] = {16'h0, r_guard[p]};
        IDX_SW_VER: w_rd_data[p] = r_sw_version;
        IDX_HW_VER: w_rd_data[p] = HW_VERSION;
        IDX_PE_ID:  w_rd_data[p] = csr_word_t'(p);
        IDX_ADD_NS: w_rd_data[p] = i_time.ns;
        IDX_READ_S: w_rd_data[p] = r_sec_snap[p];
        IDX_CMP:    w_rd_data[p] = o_cmp[p];
        IDX_STEP:   w_rd_data[p] = {24'h0, o_step};
        default: begin
          for (int k = 0; k < NUM_SHARED; k++) begin
            if (w_rd_idx[p] == reg_idx_t'(IDX_SHARED_BASE + k)) begin
              w_rd_data[p] = r_shared[k];
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    for (int p = 0; p < NUM_PE; p++) begin
      if (i_rden[p]) begin
        o_dout[p*32 +: 32] <= w_rd_data[p];
        // keeps sec consistent with the ns just returned
        if (w_rd_idx[p] == IDX_ADD_NS) begin
          r_sec_snap[p] <= i_time.sec;
        end
      end
    end
  end

endmodule

// ==== hw/sys_time.sv ====
//****************************
// seconds and nanoseconds counter
// with adjustment and second pulse
//****************************
`timescale 1ns/100ps

module sys_time import csr_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  time_adj_t  i_time_adj,
  input  logic [7:0] i_step,
  output sys_time_t  o_time,
  output logic       o_second_pulse
);

  csr_word_t w_step_ns;
  csr_word_t w_tgt_ns;
  csr_word_t w_tgt_sec;
  logic      w_ns_wrap;

  assign w_step_ns = {24'h0, i_step};
  assign w_ns_wrap = (o_time.ns >= NS_PER_SEC);

  // adjusted target, two steps for the cycles spent on the request
  always_comb begin
    w_tgt_ns  = o_time.ns + (w_step_ns << 1);
    w_tgt_sec = o_time.sec;
    if (i_time_adj.is_sec) begin
      w_tgt_sec = i_time_adj.sign ? o_time.sec + i_time_adj.amount
                                  : o_time.sec - i_time_adj.amount;
    end else begin
      w_tgt_ns = i_time_adj.sign ? w_tgt_ns + i_time_adj.amount
                                 : w_tgt_ns - i_time_adj.amount;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_time         <= '0;
      o_second_pulse <= 1'b0;
    end else begin
      o_second_pulse <= w_ns_wrap;
      if (i_time_adj.valid) begin
        // negative ns borrows a second
        if (w_tgt_ns[31]) begin
          o_time.ns  <= w_tgt_ns + NS_PER_SEC;
          o_time.sec <= w_tgt_sec - 32'd1;
        end else if (w_tgt_ns >= NS_PER_SEC) begin
          o_time.ns  <= w_tgt_ns - NS_PER_SEC;
          o_time.sec <= w_tgt_sec + 32'd1;
        end else begin
          o_time.ns  <= w_tgt_ns;
          o_time.sec <= w_tgt_sec;
        end
      end else if (w_ns_wrap) begin
        o_time.ns  <= w_step_ns;
        o_time.sec <= o_time.sec + 32'd1;
      end else begin
        o_time.ns <= o_time.ns + w_step_ns;
      end
    end
  end

endmodule

// ==== hw/pe_timer.sv ====
//****************************
// per-PE timer interrupt counters
//****************************
`timescale 1ns/100ps

module pe_timer import csr_pkg::*; #(
  parameter int NUM_PE = 3
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  csr_word_t [NUM_PE-1:0] i_cmp,
  output logic      [NUM_PE-1:0] o_time_int
);

  csr_word_t [NUM_PE-1:0] r_cnt;

  // reload at zero, period is compare + 1 cycles
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_cnt      <= '0;
      o_time_int <= '0;
    end else begin
      for (int p = 0; p < NUM_PE; p++) begin
        if (r_cnt[p] == '0) begin
          r_cnt[p]      <= i_cmp[p];
          // zero compare keeps the interrupt quiet
          o_time_int[p] <= |i_cmp[p];
        end else begin
          r_cnt[p]      <= r_cnt[p] - 32'd1;
          o_time_int[p] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hw/csr_top.sv ====
//****************************
// csr block top level
//****************************
`timescale 1ns/100ps

module csr_top import csr_pkg::*; #(
  parameter int NUM_PE     = 3,
  parameter int NUM_SHARED = 8
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // per-PE strobe ports, one word per PE
  input  logic [NUM_PE*32-1:0] i_addr,
  input  logic [NUM_PE-1:0]    i_wren,
  input  logic [NUM_PE-1:0]    i_rden,
  input  logic [NUM_PE*32-1:0] i_din,
  output logic [NUM_PE*32-1:0] o_dout,
  output logic [NUM_PE-1:0]    o_dout_valid,
  output logic [NUM_PE-1:0]    o_time_int,
  output sys_time_t            o_system_time,
  output logic                 o_second_pulse
);

  wr_cmd_t                w_wr_cmd;
  time_adj_t              w_time_adj;
  logic [7:0]             w_step;
  csr_word_t [NUM_PE-1:0] w_cmp;

  csr_req_capture #(.NUM_PE(NUM_PE)) u_capture (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_addr   (i_addr),
    .i_wren   (i_wren),
    .i_din    (i_din),
    .o_wr_cmd (w_wr_cmd)
  );

  csr_regfile #(.NUM_PE(NUM_PE), .NUM_SHARED(NUM_SHARED)) u_regfile (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_wr_cmd     (w_wr_cmd),
    .i_addr       (i_addr),
    .i_rden       (i_rden),
    .i_time       (o_system_time),
    .o_dout       (o_dout),
    .o_dout_valid (o_dout_valid),
    .o_time_adj   (w_time_adj),
    .o_step       (w_step),
    .o_cmp        (w_cmp)
  );

  sys_time u_sys_time (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_time_adj     (w_time_adj),
    .i_step         (w_step),
    .o_time         (o_system_time),
    .o_second_pulse (o_second_pulse)
  );

  pe_timer #(.NUM_PE(NUM_PE)) u_pe_timer (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cmp      (w_cmp),
    .o_time_int (o_time_int)
  );

endmodule

// ==== sim/tb_clk_gen.sv ====
//****************************
// testbench clock and reset
//****************************
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // release on a falling edge, away from the DUT clock edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// ==== sim/csr_assertions.sv ====
//****************************
// bound timing and protocol checks
// for the csr block
//****************************
`timescale 1ns/100ps

module csr_assertions import csr_pkg::*; #(
  parameter int NUM_PE = 3
) (
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic [NUM_PE-1:0]      i_rden,
  input logic [NUM_PE-1:0]      i_dout_valid,
  input logic [NUM_PE-1:0]      i_time_int,
  input csr_word_t [NUM_PE-1:0] i_cmp,
  input sys_time_t              i_time,
  input logic [7:0]             i_step,
  input logic                   i_second_pulse
);

  int                     fail_count = 0;
  csr_word_t [NUM_PE-1:0] r_gap;
  csr_word_t [NUM_PE-1:0] r_load;
  csr_word_t [NUM_PE-1:0] r_cmp_q;
  logic      [NUM_PE-1:0] r_seen;

  // cycles since the last interrupt and the value reloaded with it
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_gap   <= '0;
      r_load  <= '0;
      r_cmp_q <= '0;
      r_seen  <= '0;
    end else begin
      r_cmp_q <= i_cmp;
      for (int p = 0; p < NUM_PE; p++) begin
        if (i_time_int[p]) begin
          r_gap[p]  <= 32'd1;
          r_load[p] <= r_cmp_q[p];
          r_seen[p] <= 1'b1;
        end else begin
          r_gap[p] <= r_gap[p] + 32'd1;
        end
        if (i_cmp[p] == '0) begin
          r_seen[p] <= 1'b0;
        end
      end
    end
  end

  for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
    a_read_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rden[p] |=> i_dout_valid[p])
      else begin
        fail_count++;
        $error("PE %0d read gave no valid a cycle later", p);
      end
    a_timer_period: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_time_int[p] && r_seen[p] |-> r_gap[p] == r_load[p] + 32'd1)
      else begin
        fail_count++;
        $error("PE %0d timer period wrong", p);
      end
  end

  a_one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(i_dout_valid & ~$past(i_rden)))
    else begin
      fail_count++;
      $error("more than one write finished in a cycle");
    end

  a_ns_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_time.ns < NS_PER_SEC + {24'h0, i_step})
    else begin
      fail_count++;
      $error("nanoseconds out of range");
    end

  a_pulse_width: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_second_pulse |=> !i_second_pulse)
    else begin
      fail_count++;
      $error("second pulse wider than a cycle");
    end

  a_sec_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_second_pulse |-> i_time.sec == $past(i_time.sec) + 32'd1)
    else begin
      fail_count++;
      $error("seconds did not step with the pulse");
    end

endmodule

// ==== sim/tb_csr_top.sv ====
//****************************
// csr block testbench, stimulus
// and read-back checks
//****************************
`timescale 1ns/100ps

module tb_csr_top import csr_pkg::*; ();

  localparam int NUM_PE     = 3;
  localparam int NUM_SHARED = 8;

  logic                 clk;
  logic                 rst_n;
  logic [NUM_PE*32-1:0] addr;
  logic [NUM_PE-1:0]    wren;
  logic [NUM_PE-1:0]    rden;
  logic [NUM_PE*32-1:0] din;
  logic [NUM_PE*32-1:0] dout;
  logic [NUM_PE-1:0]    dout_valid;
  logic [NUM_PE-1:0]    time_int;
  sys_time_t            now_time;
  logic                 second_pulse;

  int        n_value_err = 0;
  int        n_timeout   = 0;
  int        n_read_err  = 0;
  int        n_assert_err;
  int        pulses;
  csr_word_t shared_exp [NUM_SHARED];
  csr_word_t rd;
  csr_word_t ns_val;
  csr_word_t s0;
  csr_word_t s1;
  csr_word_t amount;
  csr_word_t cmp_val;

  tb_clk_gen #(.PERIOD(4), .RST_CYCLES(8)) u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  csr_top #(.NUM_PE(NUM_PE), .NUM_SHARED(NUM_SHARED)) u_dut (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_addr         (addr),
    .i_wren         (wren),
    .i_rden         (rden),
    .i_din          (din),
    .o_dout         (dout),
    .o_dout_valid   (dout_valid),
    .o_time_int     (time_int),
    .o_system_time  (now_time),
    .o_second_pulse (second_pulse)
  );

  bind csr_top csr_assertions #(.NUM_PE(NUM_PE)) u_chk (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_rden         (i_rden),
    .i_dout_valid   (o_dout_valid),
    .i_time_int     (o_time_int),
    .i_cmp          (w_cmp),
    .i_time         (o_system_time),
    .i_step         (w_step),
    .i_second_pulse (o_second_pulse)
  );

  task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      n_value_err++;
    end
  endtask

  task automatic post_write(input int pe, input reg_idx_t idx, input csr_word_t data);
    addr[pe*32 +: 32] = {25'h0, idx, 2'b00};
    din[pe*32 +: 32]  = data;
    wren[pe]          = 1'b1;
  endtask

  // each posted write must finish within NUM_PE+1 cycles
  task automatic await_acks(input logic [NUM_PE-1:0] mask);
    logic [NUM_PE-1:0] seen;
    seen = '0;
    for (int k = 0; k <= NUM_PE && (seen & mask) != mask; k++) begin
      @(negedge clk);
      wren = '0;
      seen = seen | dout_valid;
    end
    for (int p = 0; p < NUM_PE; p++) begin
      if (mask[p] && !seen[p]) begin
        $display("PE %0d write was not acknowledged within %0d cycles", p, NUM_PE + 1);
        n_timeout++;
      end
    end
  endtask

  task automatic write_reg(input int pe, input reg_idx_t idx, input csr_word_t data);
    post_write(pe, idx, data);
    await_acks(NUM_PE'(1) << pe);
  endtask

  task automatic read_reg(input int pe, input reg_idx_t idx, output csr_word_t data);
    addr[pe*32 +: 32] = {25'h0, idx, 2'b00};
    rden[pe]          = 1'b1;
    @(negedge clk);
    rden[pe] = 1'b0;
    if (!dout_valid[pe]) begin
      $display("PE %0d read of index %0d returned no valid data", pe, idx);
      n_read_err++;
    end
    data = dout[pe*32 +: 32];
  endtask

  initial begin
    addr = '0;
    wren = '0;
    rden = '0;
    din  = '0;
    void'($urandom(32'h2828));
    for (int k = 0; k < 20 && rst_n !== 1'b1; k++) @(negedge clk);
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      n_timeout++;
    end
    @(negedge clk);

    // shared registers, two rounds so the last write counts
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < NUM_SHARED; k++) begin
        shared_exp[k] = $urandom;
        write_reg(k % NUM_PE, reg_idx_t'(IDX_SHARED_BASE + k), shared_exp[k]);
      end
    end
    for (int k = 0; k < NUM_SHARED; k++) begin
      read_reg((k + 1) % NUM_PE, reg_idx_t'(IDX_SHARED_BASE + k), rd);
      check_word("shared", shared_exp[k], rd);
    end

    // guard key on the software version
    write_reg(0, IDX_SW_VER, $urandom);
    read_reg(0, IDX_SW_VER, rd);
    check_word("sw version unguarded", SW_VERSION_RESET, rd);
    write_reg(0, IDX_GUARD, {16'h0, GUARD_KEY});
    s0 = $urandom;
    write_reg(0, IDX_SW_VER, s0);
    read_reg(1, IDX_SW_VER, rd);
    check_word("sw version guarded", s0, rd);
    write_reg(0, IDX_SW_VER, ~s0);
    read_reg(2, IDX_SW_VER, rd);
    check_word("sw version disarmed", s0, rd);
    for (int p = 0; p < NUM_PE; p++) begin
      read_reg(p, IDX_PE_ID, rd);
      check_word("pe id", csr_word_t'(p), rd);
    end

    // all PEs write in the same cycle
    for (int p = 0; p < NUM_PE; p++) begin
      shared_exp[p] = $urandom;
      post_write(p, reg_idx_t'(IDX_SHARED_BASE + p), shared_exp[p]);
    end
    await_acks('1);
    for (int p = 0; p < NUM_PE; p++) begin
      read_reg((p + 2) % NUM_PE, reg_idx_t'(IDX_SHARED_BASE + p), rd);
      check_word("fair shared", shared_exp[p], rd);
    end

    // timer interrupt on PE 1, then stopped with a zero compare
    cmp_val = 32'd5 + ($urandom % 32'd4);
    write_reg(1, IDX_CMP, cmp_val);
    pulses = 0;
    for (int k = 0; k < 4 * (cmp_val + 1) + 8 && pulses < 3; k++) begin
      @(negedge clk);
      if (time_int[1]) pulses++;
    end
    if (pulses < 3) begin
      $display("timer interrupt of PE 1 did not pulse three times in time");
      n_timeout++;
    end
    write_reg(1, IDX_CMP, 32'd0);
    @(negedge clk);
    pulses = 0;
    repeat (3 * (cmp_val + 1)) begin
      @(negedge clk);
      if (time_int[1]) pulses++;
    end
    check_word("timer stop", 32'd0, csr_word_t'(pulses));

    // seconds add and the private snapshot
    read_reg(2, IDX_ADD_NS, ns_val);
    read_reg(2, IDX_READ_S, s0);
    amount = ($urandom % 32'd50) + 32'd1;
    write_reg(2, IDX_GUARD, {16'h0, GUARD_KEY});
    write_reg(2, IDX_ADD_S, amount);
    read_reg(2, IDX_READ_S, rd);
    check_word("sec snapshot", s0, rd);
    read_reg(2, IDX_ADD_NS, ns_val);
    read_reg(2, IDX_READ_S, s1);
    if (s1 - s0 != amount && s1 - s0 != amount + 32'd1) begin
      $display("Fail sec add: expected %h, actual %h", amount, s1 - s0);
      n_value_err++;
    end

    // big step and an ns add that lands just short of a second
    write_reg(0, IDX_GUARD, {16'h0, GUARD_KEY});
    write_reg(0, IDX_STEP, 32'd255);
    read_reg(0, IDX_STEP, rd);
    check_word("step", 32'd255, rd);
    read_reg(0, IDX_ADD_NS, ns_val);
    write_reg(0, IDX_GUARD, {16'h0, GUARD_KEY});
    write_reg(0, IDX_ADD_NS, NS_PER_SEC - ns_val - 32'd20000);
    pulses = 0;
    for (int k = 0; k < 200 && pulses == 0; k++) begin
      @(negedge clk);
      if (second_pulse) pulses++;
    end
    if (pulses == 0) begin
      $display("second pulse did not arrive within 200 cycles");
      n_timeout++;
    end
    repeat (3) @(negedge clk);

    n_assert_err = u_dut.u_chk.fail_count;
    $display("errors: %0d value, %0d timeout, %0d read, %0d assertion",
             n_value_err, n_timeout, n_read_err, n_assert_err);
    if (n_value_err + n_timeout + n_read_err + n_assert_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/csr_pkg.sv
hw/csr_req_capture.sv
hw/csr_regfile.sv
hw/sys_time.sv
hw/pe_timer.sv
hw/csr_top.sv
sim/tb_clk_gen.sv
sim/csr_assertions.sv
sim/tb_csr_top.sv

// ==== Makefile ====
# Verilator build and run of the csr block testbench
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_csr_top \
		-f verilog.f -Mdir $(BUILD) -o tb_csr_top

run: compile
	./$(BUILD)/tb_csr_top +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
